// File: rtl/gamePkg.sv
package gamePkg;

	// pixel colour and game data widths
	localparam int RGB_WIDTH = 8;
	localparam int SCORE_WIDTH = 16;
	localparam int PLAYER_WIDTH = 4;
	localparam int LIFE_WIDTH = 4;

	// entries in the top score table
	localparam int TOP_DEPTH = 3;

	// position of a new entry in the table, TOP_DEPTH means it stays out
	localparam int RANK_WIDTH = $clog2(TOP_DEPTH + 1);

	// clock cycles per second at 50 MHz
	localparam int TICKS_PER_SECOND = 50_000_000;

	// seconds spent on the end screen
	localparam int END_SECONDS = 5;
	localparam int SECOND_COUNT_WIDTH = $clog2(END_SECONDS + 1);

	// screen sequence, also selects the pixel stream
	typedef enum logic [1:0] {
		WELCOME,
		PLAYING,
		SUBMIT,
		ENDING
	} screenState;

endpackage

// File: rtl/secondTicker.sv
module secondTicker import gamePkg::*; #(
	parameter int tickPeriod = TICKS_PER_SECOND
) (
	input	logic	clk,
	input	logic	reset,
	input	logic	clear,
	output	logic	secondPulse
);

localparam int countWidth = (tickPeriod > 1) ? $clog2(tickPeriod) : 1;

logic	[countWidth-1:0]	cycleCount;

always_ff @(posedge clk) begin
	if (reset || clear) begin
		cycleCount <= '0;
		secondPulse <= 1'b0;
	end else if (cycleCount == countWidth'(tickPeriod - 1)) begin
		// terminal count, wrap and fire
		cycleCount <= '0;
		secondPulse <= 1'b1;
	end else begin
		cycleCount <= cycleCount + 1'b1;
		secondPulse <= 1'b0;
	end
end

endmodule

// File: rtl/screenController.sv
module screenController import gamePkg::*; (
	input	logic						clk,
	input	logic						reset,
	input	logic						startKey,
	input	logic						backKey,
	input	logic						secondPulse,
	input	logic						scoreAck,
	input	logic	[LIFE_WIDTH-1:0]	life,
	input	logic	[SCORE_WIDTH-1:0]	score,
	input	logic	[PLAYER_WIDTH-1:0]	playerId,
	output	screenState					state,
	output	logic						tickClear,
	output	logic						scoreReq,
	output	logic	[SCORE_WIDTH-1:0]	reqScore,
	output	logic	[PLAYER_WIDTH-1:0]	reqPlayer
);

logic	[SECOND_COUNT_WIDTH-1:0]	secondCount;
logic								countedPulse;
logic								gameStart;
logic								gameOver;
logic								lastSecond;

assign gameStart = (state == WELCOME) && startKey;
assign gameOver = (state == PLAYING) && (life == '0);

// a pulse from before the ticker was cleared is not a whole second
assign countedPulse = secondPulse && !tickClear;
assign lastSecond = (secondCount == SECOND_COUNT_WIDTH'(END_SECONDS - 1));

always_ff @(posedge clk) begin
	if (reset) begin
		state <= WELCOME;
		tickClear <= 1'b0;
		scoreReq <= 1'b0;
		secondCount <= '0;
	end else begin
		tickClear <= 1'b0;
		case (state)
			WELCOME: begin
				if (gameStart) begin
					state <= PLAYING;
				end
			end
			PLAYING: begin
				if (gameOver) begin
					state <= SUBMIT;
					scoreReq <= 1'b1;
				end
			end
			SUBMIT: begin
				// keys are ignored until the board has the score
				if (scoreReq && scoreAck) begin
					scoreReq <= 1'b0;
				end else if (!scoreReq && !scoreAck) begin
					state <= ENDING;
					tickClear <= 1'b1;
					secondCount <= '0;
				end
			end
			ENDING: begin
				if (backKey) begin
					state <= WELCOME;
				end else if (countedPulse) begin
					if (lastSecond) begin
						state <= WELCOME;
					end else begin
						secondCount <= secondCount + 1'b1;
					end
				end
			end
			default: begin
				state <= WELCOME;
			end
		endcase
	end
end

// player and final score, held steady through the handshake
always_ff @(posedge clk) begin
	if (gameStart) begin
		reqPlayer <= playerId;
	end
	if (gameOver) begin
		reqScore <= score;
	end
end

endmodule

// File: rtl/scoreBoard.sv
module scoreBoard import gamePkg::*; (
	input	logic						clk,
	input	logic						reset,
	input	logic						scoreReq,
	input	logic	[SCORE_WIDTH-1:0]	reqScore,
	input	logic	[PLAYER_WIDTH-1:0]	reqPlayer,
	output	logic						scoreAck,
	output	logic	[SCORE_WIDTH-1:0]	topScore0,
	output	logic	[SCORE_WIDTH-1:0]	topScore1,
	output	logic	[SCORE_WIDTH-1:0]	topScore2,
	output	logic	[PLAYER_WIDTH-1:0]	topPlayer0,
	output	logic	[PLAYER_WIDTH-1:0]	topPlayer1,
	output	logic	[PLAYER_WIDTH-1:0]	topPlayer2
);

// entry 0 holds the best score
logic	[SCORE_WIDTH-1:0]	scoreTable	[TOP_DEPTH];
logic	[PLAYER_WIDTH-1:0]	playerTable	[TOP_DEPTH];
logic	[RANK_WIDTH-1:0]	newRank;
logic						insertNow;

// new entry goes below every entry it does not strictly beat
always_comb begin
	newRank = '0;
	for (int i = 0; i < TOP_DEPTH; i++) begin
		if (scoreTable[i] >= reqScore) begin
			newRank = newRank + 1'b1;
		end
	end
end

// first cycle of a request only, so each one lands once
assign insertNow = scoreReq && !scoreAck;

always_ff @(posedge clk) begin
	if (reset) begin
		scoreAck <= 1'b0;
		for (int i = 0; i < TOP_DEPTH; i++) begin
			scoreTable[i] <= '0;
			playerTable[i] <= '0;
		end
	end else if (insertNow) begin
		scoreAck <= 1'b1;
		// entries below the new one move down, the last falls out
		for (int i = TOP_DEPTH - 1; i > 0; i--) begin
			if (RANK_WIDTH'(i) > newRank) begin
				scoreTable[i] <= scoreTable[i-1];
				playerTable[i] <= playerTable[i-1];
			end
		end
		if (newRank < RANK_WIDTH'(TOP_DEPTH)) begin
			scoreTable[newRank] <= reqScore;
			playerTable[newRank] <= reqPlayer;
		end
	end else if (!scoreReq) begin
		scoreAck <= 1'b0;
	end
end

assign topScore0 = scoreTable[0];
assign topScore1 = scoreTable[1];
assign topScore2 = scoreTable[2];
assign topPlayer0 = playerTable[0];
assign topPlayer1 = playerTable[1];
assign topPlayer2 = playerTable[2];

endmodule

// File: rtl/screenMux.sv
module screenMux import gamePkg::*; (
	input	logic						clk,
	input	logic						reset,
	input	screenState					state,
	input	logic	[RGB_WIDTH-1:0]		rgbWelcome,
	input	logic	[RGB_WIDTH-1:0]		rgbMain,
	input	logic	[RGB_WIDTH-1:0]		rgbEnd,
	output	logic	[RGB_WIDTH-1:0]		rgb
);

always_ff @(posedge clk) begin
	if (reset) begin
		rgb <= '0;
	end else begin
		unique case (state)
			WELCOME: rgb <= rgbWelcome;
			// main screen stays up while the score is handed over
			PLAYING, SUBMIT: rgb <= rgbMain;
			ENDING: rgb <= rgbEnd;
		endcase
	end
end

endmodule

// File: rtl/gameTop.sv
module gameTop import gamePkg::*; #(
	parameter int tickPeriod = TICKS_PER_SECOND
) (
	input	logic						clk,
	input	logic						reset,
	input	logic						startKey,
	input	logic						backKey,
	input	logic	[LIFE_WIDTH-1:0]	life,
	input	logic	[SCORE_WIDTH-1:0]	score,
	input	logic	[PLAYER_WIDTH-1:0]	playerId,
	input	logic	[RGB_WIDTH-1:0]		rgbWelcome,
	input	logic	[RGB_WIDTH-1:0]		rgbMain,
	input	logic	[RGB_WIDTH-1:0]		rgbEnd,
	output	screenState					state,
	output	logic	[RGB_WIDTH-1:0]		rgb,
	output	logic	[SCORE_WIDTH-1:0]	topScore0,
	output	logic	[SCORE_WIDTH-1:0]	topScore1,
	output	logic	[SCORE_WIDTH-1:0]	topScore2,
	output	logic	[PLAYER_WIDTH-1:0]	topPlayer0,
	output	logic	[PLAYER_WIDTH-1:0]	topPlayer1,
	output	logic	[PLAYER_WIDTH-1:0]	topPlayer2
);

logic						secondPulse;
logic						tickClear;
logic						scoreReq;
logic						scoreAck;
logic	[SCORE_WIDTH-1:0]	reqScore;
logic	[PLAYER_WIDTH-1:0]	reqPlayer;

secondTicker #(
	.tickPeriod(tickPeriod)
) secondTickerInst (
// input
	.clk(clk),
	.reset(reset),
	.clear(tickClear),
// output
	.secondPulse(secondPulse)
);

screenController screenControllerInst (
// input
	.clk(clk),
	.reset(reset),
	.startKey(startKey),
	.backKey(backKey),
	.secondPulse(secondPulse),
	.scoreAck(scoreAck),
	.life(life),
	.score(score),
	.playerId(playerId),
// output
	.state(state),
	.tickClear(tickClear),
	.scoreReq(scoreReq),
	.reqScore(reqScore),
	.reqPlayer(reqPlayer)
);

scoreBoard scoreBoardInst (
// input
	.clk(clk),
	.reset(reset),
	.scoreReq(scoreReq),
	.reqScore(reqScore),
	.reqPlayer(reqPlayer),
// output
	.scoreAck(scoreAck),
	.topScore0(topScore0),
	.topScore1(topScore1),
	.topScore2(topScore2),
	.topPlayer0(topPlayer0),
	.topPlayer1(topPlayer1),
	.topPlayer2(topPlayer2)
);

screenMux screenMuxInst (
// input
	.clk(clk),
	.reset(reset),
	.state(state),
	.rgbWelcome(rgbWelcome),
	.rgbMain(rgbMain),
	.rgbEnd(rgbEnd),
// output
	.rgb(rgb)
);

endmodule

// File: dv/game_chk.sv
module gameChk import gamePkg::*; (
	input	logic						clk,
	input	logic						reset,
	input	screenState					state,
	input	logic						scoreReq,
	input	logic						scoreAck,
	input	logic	[SCORE_WIDTH-1:0]	reqScore,
	input	logic	[PLAYER_WIDTH-1:0]	reqPlayer
);

timeunit 1ns;
timeprecision 1ps;

// requester holds until the board has answered
reqHeldUntilAck: assert property (@(posedge clk) disable iff (reset)
	$fell(scoreReq) |-> scoreAck)
	else $error("score request dropped before its acknowledge");

reqDataStable: assert property (@(posedge clk) disable iff (reset)
	(scoreReq && $past(scoreReq)) |-> ($stable(reqScore) && $stable(reqPlayer)))
	else $error("request data changed while the request was up");

// new request only after the last one is fully closed
reqRiseAckLow: assert property (@(posedge clk) disable iff (reset)
	$rose(scoreReq) |-> !scoreAck)
	else $error("score request raised while acknowledge still high");

reqOnlyInSubmit: assert property (@(posedge clk) disable iff (reset)
	scoreReq |-> (state == SUBMIT))
	else $error("score request outside the submit screen");

stateKnown: assert property (@(posedge clk) disable iff (reset)
	!$isunknown(state))
	else $error("screen state is unknown");

endmodule

bind screenController gameChk chk (
	.clk(clk),
	.reset(reset),
	.state(state),
	.scoreReq(scoreReq),
	.scoreAck(scoreAck),
	.reqScore(reqScore),
	.reqPlayer(reqPlayer)
);

// File: dv/gameTb.sv
module gameTb import gamePkg::*; ();

timeunit 1ns;
timeprecision 1ps;

localparam int tbTickPeriod = 20;
localparam int endCycles = END_SECONDS * tbTickPeriod;

// one row per game: player, final score, rank it should land at, exit by backKey
localparam int sessionCount = 8;
localparam logic [PLAYER_WIDTH-1:0] sessionPlayer [sessionCount] =
	'{4'd1, 4'd2, 4'd3, 4'd4, 4'd5, 4'd6, 4'd7, 4'd8};
localparam logic [SCORE_WIDTH-1:0] sessionScore [sessionCount] =
	'{16'd100, 16'd300, 16'd200, 16'd200, 16'd50, 16'd300, 16'd1000, 16'd300};
localparam int sessionRank [sessionCount] = '{0, 0, 1, 2, 3, 1, 0, 3};
localparam logic sessionBack [sessionCount] =
	'{1'b1, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1, 1'b1, 1'b0};

logic						clk;
logic						reset;
logic						startKey;
logic						backKey;
logic	[LIFE_WIDTH-1:0]	life;
logic	[SCORE_WIDTH-1:0]	score;
logic	[PLAYER_WIDTH-1:0]	playerId;
logic	[RGB_WIDTH-1:0]		rgbWelcome;
logic	[RGB_WIDTH-1:0]		rgbMain;
logic	[RGB_WIDTH-1:0]		rgbEnd;
screenState					state;
logic	[RGB_WIDTH-1:0]		rgb;
logic	[SCORE_WIDTH-1:0]	topScore0;
logic	[SCORE_WIDTH-1:0]	topScore1;
logic	[SCORE_WIDTH-1:0]	topScore2;
logic	[PLAYER_WIDTH-1:0]	topPlayer0;
logic	[PLAYER_WIDTH-1:0]	topPlayer1;
logic	[PLAYER_WIDTH-1:0]	topPlayer2;

logic	[SCORE_WIDTH-1:0]	modelScore	[TOP_DEPTH];
logic	[PLAYER_WIDTH-1:0]	modelPlayer	[TOP_DEPTH];
logic	[15:0]				lfsrState;
int							checkErrors;
int							rgbErrors;
int							timeoutErrors;
logic						monitorOn;

gameTop #(
	.tickPeriod(tbTickPeriod)
) uut (
	.clk(clk),
	.reset(reset),
	.startKey(startKey),
	.backKey(backKey),
	.life(life),
	.score(score),
	.playerId(playerId),
	.rgbWelcome(rgbWelcome),
	.rgbMain(rgbMain),
	.rgbEnd(rgbEnd),
	.state(state),
	.rgb(rgb),
	.topScore0(topScore0),
	.topScore1(topScore1),
	.topScore2(topScore2),
	.topPlayer0(topPlayer0),
	.topPlayer1(topPlayer1),
	.topPlayer2(topPlayer2)
);

initial begin
	clk = 1'b0;
	forever #4 clk = ~clk;
end

// taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] cur);
	return {cur[14:0], cur[15] ^ cur[13] ^ cur[12] ^ cur[10]};
endfunction

function automatic logic [RGB_WIDTH-1:0] randomPixel();
	logic [RGB_WIDTH-1:0] value;
	value = '0;
	for (int i = 0; i < RGB_WIDTH; i++) begin
		lfsrState = lfsrNext(lfsrState);
		value = {value[RGB_WIDTH-2:0], lfsrState[0]};
	end
	return value;
endfunction

// fresh screen pixels every cycle
initial begin
	lfsrState = 16'd64892;
	rgbWelcome = '0;
	rgbMain = '0;
	rgbEnd = '0;
	forever begin
		@(posedge clk);
		#1;
		rgbWelcome = randomPixel();
		rgbMain = randomPixel();
		rgbEnd = randomPixel();
	end
end

// rgb follows last cycle's state and pixels
always @(negedge clk) begin : rgbMonitor
	logic [RGB_WIDTH-1:0] expectedRgb;
	static logic prevValid = 1'b0;
	static screenState prevState = WELCOME;
	static logic [RGB_WIDTH-1:0] prevWelcome = '0;
	static logic [RGB_WIDTH-1:0] prevMain = '0;
	static logic [RGB_WIDTH-1:0] prevEnd = '0;
	if (monitorOn && prevValid) begin
		case (prevState)
			WELCOME: expectedRgb = prevWelcome;
			PLAYING, SUBMIT: expectedRgb = prevMain;
			ENDING: expectedRgb = prevEnd;
			default: expectedRgb = '0;
		endcase
		assert (rgb === expectedRgb) else begin
			rgbErrors++;
			$display("Mismatch rgb: got 0x%0h, expected 0x%0h", rgb, expectedRgb);
		end
	end
	prevValid = monitorOn;
	prevState = state;
	prevWelcome = rgbWelcome;
	prevMain = rgbMain;
	prevEnd = rgbEnd;
end

task automatic stepCycle();
	@(posedge clk);
	#1;
endtask

task automatic checkValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
	assert (got === expected) else begin
		checkErrors++;
		$display("Mismatch %s: got 0x%0h, expected 0x%0h", name, got, expected);
	end
endtask

task automatic waitForState(input screenState target, input int limit, output int cycles);
	cycles = 0;
	while (state != target && cycles < limit) begin
		stepCycle();
		cycles++;
	end
	if (state != target) begin
		timeoutErrors++;
		$display("Timeout: state stuck at %s, never reached %s within %0d cycles",
			state.name(), target.name(), limit);
	end
endtask

// new score lands above the first entry it strictly beats
function automatic void modelInsert(input logic [SCORE_WIDTH-1:0] newScore,
		input logic [PLAYER_WIDTH-1:0] newPlayer);
	int rank;
	rank = TOP_DEPTH;
	for (int i = TOP_DEPTH - 1; i >= 0; i--) begin
		if (newScore > modelScore[i]) begin
			rank = i;
		end
	end
	for (int i = TOP_DEPTH - 1; i > rank; i--) begin
		modelScore[i] = modelScore[i-1];
		modelPlayer[i] = modelPlayer[i-1];
	end
	if (rank < TOP_DEPTH) begin
		modelScore[rank] = newScore;
		modelPlayer[rank] = newPlayer;
	end
endfunction

function automatic logic [PLAYER_WIDTH-1:0] playerAt(input int rank);
	case (rank)
		0: return topPlayer0;
		1: return topPlayer1;
		default: return topPlayer2;
	endcase
endfunction

task automatic checkTable();
	checkValue("topScore0", 32'(topScore0), 32'(modelScore[0]));
	checkValue("topScore1", 32'(topScore1), 32'(modelScore[1]));
	checkValue("topScore2", 32'(topScore2), 32'(modelScore[2]));
	checkValue("topPlayer0", 32'(topPlayer0), 32'(modelPlayer[0]));
	checkValue("topPlayer1", 32'(topPlayer1), 32'(modelPlayer[1]));
	checkValue("topPlayer2", 32'(topPlayer2), 32'(modelPlayer[2]));
endtask

task automatic runSession(input int row);
	int cycles;
	waitForState(WELCOME, 10, cycles);
	playerId = sessionPlayer[row];
	life = 4'd3;
	score = '0;
	startKey = 1'b1;
	stepCycle();
	startKey = 1'b0;
	checkValue("state", 32'(state), 32'(PLAYING));
	for (int i = 0; i < 4; i++) begin
		score = score + 16'd7;
		stepCycle();
	end
	checkValue("state", 32'(state), 32'(PLAYING));
	life = '0;
	score = sessionScore[row];
	stepCycle();
	checkValue("state", 32'(state), 32'(SUBMIT));
	// later inputs must not reach the latched request
	score = 16'hffff;
	playerId = ~sessionPlayer[row];
	startKey = 1'b1;
	stepCycle();
	startKey = 1'b0;
	assert (state == SUBMIT || state == ENDING) else begin
		checkErrors++;
		$display("startKey during SUBMIT moved the state to %s", state.name());
	end
	waitForState(ENDING, 50, cycles);
	modelInsert(sessionScore[row], sessionPlayer[row]);
	checkTable();
	if (sessionRank[row] < TOP_DEPTH) begin
		checkValue("topPlayer", 32'(playerAt(sessionRank[row])), 32'(sessionPlayer[row]));
	end
	startKey = 1'b1;
	stepCycle();
	startKey = 1'b0;
	checkValue("state", 32'(state), 32'(ENDING));
	if (sessionBack[row]) begin
		backKey = 1'b1;
		stepCycle();
		backKey = 1'b0;
		checkValue("state", 32'(state), 32'(WELCOME));
	end else begin
		waitForState(WELCOME, endCycles + 2 * tbTickPeriod, cycles);
		cycles = cycles + 1;
		assert (cycles >= endCycles && cycles <= endCycles + tbTickPeriod) else begin
			checkErrors++;
			$display("end screen lasted %0d cycles, expected %0d to %0d",
				cycles, endCycles, endCycles + tbTickPeriod);
		end
	end
endtask

initial begin
	reset = 1'b1;
	startKey = 1'b0;
	backKey = 1'b0;
	life = '0;
	score = '0;
	playerId = '0;
	checkErrors = 0;
	rgbErrors = 0;
	timeoutErrors = 0;
	monitorOn = 1'b0;
	for (int i = 0; i < TOP_DEPTH; i++) begin
		modelScore[i] = '0;
		modelPlayer[i] = '0;
	end
	repeat (2) @(posedge clk);
	#1;
	checkValue("state", 32'(state), 32'(WELCOME));
	checkValue("rgb", 32'(rgb), 32'h0);
	checkTable();
	reset = 1'b0;
	monitorOn = 1'b1;
	for (int row = 0; row < sessionCount; row++) begin
		runSession(row);
	end
	$display("errors: %0d mismatches, %0d rgb mismatches, %0d timeouts",
		checkErrors, rgbErrors, timeoutErrors);
	if (checkErrors + rgbErrors + timeoutErrors == 0) begin
		$display("TEST PASS");
	end else begin
		$display("TEST FAIL");
	end
	$finish;
end

endmodule

// File: flist.f
rtl/gamePkg.sv
rtl/secondTicker.sv
rtl/screenController.sv
rtl/scoreBoard.sv
rtl/screenMux.sv
rtl/gameTop.sv
dv/game_chk.sv
dv/gameTb.sv

// File: Makefile
TOOL       ?= verilator
FLAGS      ?= --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS ?= --lint-only --timing --assert --timescale 1ns/1ps
TOP        ?= gameTb
FILELIST   ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
